// File: rtl/tag_pkg.sv
/*
 * tag configuration network package
 * payload types, widths, receive-side defaults and client index
 * shared by the tag master, the bit counter and the top level
 */
package tag_pkg;

   // bit counts of each client payload
   localparam int clkdiv_width_lp = 8;
   localparam int mode_width_lp   = 12;

   // widest payload, sizes the host command data
   localparam int max_width_lp    = 12;

   // counter must hold max_width_lp
   localparam int cnt_width_lp    = 4;

   // client 0 payload, raw divider setting
   typedef logic [clkdiv_width_lp-1:0] clkdiv_cfg_t;

   // client 1 payload, msb first in declaration order
   typedef struct packed {
      logic [3:0] mode;
      logic [5:0] threshold;
      logic [1:0] lane;
   } mode_cfg_t;

   // values installed by the receive reset
   localparam clkdiv_cfg_t clkdiv_default_lp = 8'h10;
   localparam mode_cfg_t   mode_default_lp   = '{mode: 4'h3, threshold: 6'h20, lane: 2'h1};

   // which tag bus a host command goes to
   typedef enum logic {
      client_clkdiv_e = 1'b0,
      client_mode_e   = 1'b1
   } client_sel_t;

endpackage

// File: rtl/tag_bus_if.sv
/*
 * tag bus
 * one serial configuration link from the master to a client
 * clk and en come from the top, op and param from the master
 */
`timescale 1ns/100ps

interface tag_bus_if;

   // tag domain clock
   logic clk;
   // op high shifts param in, op low selects reset or no-op by param
   logic op;
   logic param;
   // level from off chip, gates all receive updates
   logic en;

   modport master (
      output op,
      output param
   );

   modport client (
      input clk,
      input op,
      input param,
      input en
   );

endinterface

// File: rtl/tag_bit_counter.sv
/*
 * tag bit counter
 * remaining shift bits of the current command
 * loaded on acceptance, decremented once per shift cycle
 */
`timescale 1ns/100ps

module tag_bit_counter (
   input  logic                             tag_clk_i,
   input  logic                             tag_reset_i,
   input  logic                             load_i,
   input  logic [tag_pkg::cnt_width_lp-1:0] load_value_i,
   input  logic                             dec_i,
   output logic                             last_o
);

   import tag_pkg::*;

   logic [cnt_width_lp-1:0] cnt_r;

   always_ff @(posedge tag_clk_i)
   begin
      if (tag_reset_i)
         cnt_r <= '0;
      else if (load_i)
         cnt_r <= load_value_i;
      else if (dec_i)
         cnt_r <= cnt_r - 1'b1;
   end

   // one bit left, this shift cycle is the final one
   assign last_o = (cnt_r == cnt_width_lp'(1));

   // master must leave shift before the count runs out
   a_no_underflow: assert property (@(posedge tag_clk_i) disable iff (tag_reset_i)
      dec_i |-> (cnt_r != '0));

endmodule

// File: rtl/tag_toggle_sync.sv
/*
 * toggle launch and synchronizer
 * launch flop in the tag domain flips once per send and is cleared
 * by the tag-side reset op, two receive flops bring it across
 */
`timescale 1ns/100ps

module tag_toggle_sync (
   input  logic iclk_i,
   input  logic iclk_reset_i,
   input  logic iclk_flip_i,
   output logic iclk_toggle_o,
   input  logic oclk_i,
   output logic oclk_toggle_o
);

   logic launch_r;
   logic sync1_r;
   logic sync2_r;

   // launch flop, nothing combinational in front of the crossing
   always_ff @(posedge iclk_i)
   begin
      if (iclk_reset_i)
         launch_r <= 1'b0;
      else if (iclk_flip_i)
         launch_r <= ~launch_r;
   end

   // two-flop synchronizer in the receive domain
   always_ff @(posedge oclk_i)
   begin
      sync1_r <= launch_r;
      sync2_r <= sync1_r;
   end

   assign iclk_toggle_o = launch_r;
   assign oclk_toggle_o = sync2_r;

endmodule

// File: rtl/tag_master_fsm.sv
/*
 * tag master state machine
 * sends one reset op on both buses after tag reset, then serializes
 * accepted host commands lsb first onto the selected bus,
 * followed by two no-op cycles so the client detects the send
 */
`timescale 1ns/100ps

module tag_master_fsm (
   input  logic                               tag_clk_i,
   input  logic                               tag_reset_i,
   input  logic                               cmd_valid_i,
   input  tag_pkg::client_sel_t               cmd_sel_i,
   input  logic [tag_pkg::max_width_lp-1:0]   cmd_data_i,
   input  logic                               cnt_last_i,
   output logic                               cnt_load_o,
   output logic                               cnt_dec_o,
   output logic                               busy_o,
   tag_bus_if.master                          bus_clkdiv_o,
   tag_bus_if.master                          bus_mode_o
);

   import tag_pkg::*;

   typedef enum logic [1:0] {
      init_s,
      idle_s,
      shift_s,
      flush_s
   } state_e;

   state_e                  state_r;
   state_e                  state_n;
   logic                    busy_r;
   logic                    flush_cnt_r;
   client_sel_t             sel_r;
   logic [max_width_lp-1:0] data_r;
   logic                    accept;
   logic                    shift_clkdiv;
   logic                    shift_mode;

   // commands only taken in idle, i.e. while busy is low
   assign accept = (state_r == idle_s) & cmd_valid_i;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         init_s:  state_n = idle_s;
         idle_s:  if (cmd_valid_i) state_n = shift_s;
         // counter flags the final bit
         shift_s: if (cnt_last_i) state_n = flush_s;
         flush_s: if (flush_cnt_r) state_n = idle_s;
         default: state_n = init_s;
      endcase
   end

   always_ff @(posedge tag_clk_i)
   begin
      if (tag_reset_i)
      begin
         state_r     <= init_s;
         busy_r      <= 1'b1;
         flush_cnt_r <= 1'b0;
         sel_r       <= client_clkdiv_e;
      end
      else
      begin
         state_r     <= state_n;
         // busy follows the next state so it drops together with idle
         busy_r      <= (state_n != idle_s);
         // second flush cycle marker
         flush_cnt_r <= (state_r == flush_s) & ~flush_cnt_r;
         if (accept)
            sel_r <= cmd_sel_i;
      end
   end

   // command data, shifted right once per sent bit
   always_ff @(posedge tag_clk_i)
   begin
      if (accept)
         data_r <= cmd_data_i;
      else if (state_r == shift_s)
         data_r <= data_r >> 1;
   end

   // only the selected bus sees shift ops
   assign shift_clkdiv = (state_r == shift_s) & (sel_r == client_clkdiv_e);
   assign shift_mode   = (state_r == shift_s) & (sel_r == client_mode_e);

   // init drives the reset op (op low, param high) on both buses
   assign bus_clkdiv_o.op    = shift_clkdiv;
   assign bus_clkdiv_o.param = (state_r == init_s) | (shift_clkdiv & data_r[0]);
   assign bus_mode_o.op      = shift_mode;
   assign bus_mode_o.param   = (state_r == init_s) | (shift_mode & data_r[0]);

   assign cnt_load_o = accept;
   assign cnt_dec_o  = (state_r == shift_s);
   assign busy_o     = busy_r;

   // registered busy must cover every shift cycle
   a_busy_in_shift: assert property (@(posedge tag_clk_i) disable iff (tag_reset_i)
      (state_r == shift_s) |-> busy_o);

endmodule

// File: rtl/tag_client.sv
/*
 * tag client
 * shifts serial param bits into a payload register in the tag domain,
 * flags the send on the following no-op and hands the value over to
 * the receive domain with a one-cycle new-value pulse
 * receive reset installs default_p, en gates all receive updates
 */
`timescale 1ns/100ps

module tag_client #(
   parameter type      payload_t = logic [7:0],
   parameter payload_t default_p = payload_t'(0)
) (
   tag_bus_if.client bus_i,
   input  logic      recv_clk_i,
   input  logic      recv_reset_i,
   output logic      recv_new_o,
   output payload_t  recv_data_o
);

   localparam int width_lp = $bits(payload_t);

   logic                op_r;
   logic                op_r_r;
   logic                param_r;
   logic                reset_op;
   logic                shift_op;
   logic                no_op;
   logic                send_now;
   logic [width_lp-1:0] tag_shift_r;
   logic [width_lp-1:0] tag_data_r;
   logic                recv_toggle;
   logic                recv_toggle_r;
   logic                recv_new;
   logic                recv_new_r;
   logic                recv_new_r_r;
   payload_t            recv_data_r;

   // bus bits registered once, op twice for send detection
   always_ff @(posedge bus_i.clk)
   begin
      op_r    <= bus_i.op;
      param_r <= bus_i.param;
      op_r_r  <= op_r;
   end

   assign reset_op = ~op_r & param_r;
   assign shift_op = op_r;
   assign no_op    = ~op_r & ~param_r;

   // first no-op after a shift, shift register already holds the value
   assign send_now = op_r_r & no_op;

   // new bit enters at the top, first bit ends up in bit 0
   always_ff @(posedge bus_i.clk)
   begin
      if (shift_op)
         tag_shift_r <= {param_r, tag_shift_r[width_lp-1:1]};
   end

   // value held for the receive side until the next send
   always_ff @(posedge bus_i.clk)
   begin
      if (send_now)
         tag_data_r <= tag_shift_r;
   end

   tag_toggle_sync u_toggle_sync (
      .iclk_i        (bus_i.clk),
      .iclk_reset_i  (reset_op),
      .iclk_flip_i   (send_now),
      .iclk_toggle_o (),
      .oclk_i        (recv_clk_i),
      .oclk_toggle_o (recv_toggle)
   );

   // edge on the synchronized toggle marks a send
   assign recv_new = (recv_toggle_r ^ recv_toggle) & bus_i.en;

   // previous toggle tracks through reset so a later reset sees no edge
   always_ff @(posedge recv_clk_i)
   begin
      recv_toggle_r <= recv_toggle;
   end

   // extra stage between edge detect and the wide load
   always_ff @(posedge recv_clk_i)
   begin
      if (recv_reset_i)
      begin
         recv_new_r   <= 1'b0;
         // announces the default right after reset
         recv_new_r_r <= 1'b1;
      end
      else
      begin
         recv_new_r   <= recv_new;
         recv_new_r_r <= recv_new_r;
      end
   end

   // tag_data_r is stable here, the send finished cycles ago
   always_ff @(posedge recv_clk_i)
   begin
      if (recv_reset_i)
         recv_data_r <= default_p;
      else if (recv_new_r)
         recv_data_r <= payload_t'(tag_data_r);
   end

   // en applied after the flop, holds even without a running tag clock
   assign recv_new_o  = recv_new_r_r & bus_i.en;
   assign recv_data_o = recv_data_r;

   // toggle spacing guarantees isolated pulses
   a_single_pulse: assert property (@(posedge recv_clk_i) disable iff (recv_reset_i)
      recv_new_o |=> !recv_new_o);

endmodule

// File: rtl/tag_subsystem_top.sv
/*
 * tag subsystem top
 * tag master and bit counter driving two dedicated tag buses,
 * one client for the clock divider setting and one for the mode word
 */
`timescale 1ns/100ps

module tag_subsystem_top (
   input  logic                             tag_clk_i,
   input  logic                             tag_reset_i,
   input  logic                             tag_en_i,
   input  logic                             recv_clk_i,
   input  logic                             recv_reset_i,
   input  logic                             cmd_valid_i,
   input  tag_pkg::client_sel_t             cmd_sel_i,
   input  logic [tag_pkg::max_width_lp-1:0] cmd_data_i,
   output logic                             busy_o,
   output logic                             clkdiv_new_o,
   output tag_pkg::clkdiv_cfg_t             clkdiv_o,
   output logic                             mode_new_o,
   output tag_pkg::mode_cfg_t               mode_o
);

   import tag_pkg::*;

   logic                    cnt_load;
   logic                    cnt_dec;
   logic                    cnt_last;
   logic [cnt_width_lp-1:0] cnt_load_value;

   tag_bus_if clkdiv_bus ();
   tag_bus_if mode_bus ();

   // shared clock and enable level on both buses
   assign clkdiv_bus.clk = tag_clk_i;
   assign clkdiv_bus.en  = tag_en_i;
   assign mode_bus.clk   = tag_clk_i;
   assign mode_bus.en    = tag_en_i;

   // bit count of the addressed client, sampled with the load strobe
   assign cnt_load_value = (cmd_sel_i == client_mode_e) ? cnt_width_lp'(mode_width_lp)
                                                       : cnt_width_lp'(clkdiv_width_lp);

   tag_master_fsm u_master (
      .tag_clk_i    (tag_clk_i),
      .tag_reset_i  (tag_reset_i),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_sel_i    (cmd_sel_i),
      .cmd_data_i   (cmd_data_i),
      .cnt_last_i   (cnt_last),
      .cnt_load_o   (cnt_load),
      .cnt_dec_o    (cnt_dec),
      .busy_o       (busy_o),
      .bus_clkdiv_o (clkdiv_bus.master),
      .bus_mode_o   (mode_bus.master)
   );

   tag_bit_counter u_counter (
      .tag_clk_i    (tag_clk_i),
      .tag_reset_i  (tag_reset_i),
      .load_i       (cnt_load),
      .load_value_i (cnt_load_value),
      .dec_i        (cnt_dec),
      .last_o       (cnt_last)
   );

   tag_client #(.payload_t(clkdiv_cfg_t), .default_p(clkdiv_default_lp)) u_clkdiv_client (
      .bus_i        (clkdiv_bus.client),
      .recv_clk_i   (recv_clk_i),
      .recv_reset_i (recv_reset_i),
      .recv_new_o   (clkdiv_new_o),
      .recv_data_o  (clkdiv_o)
   );

   tag_client #(.payload_t(mode_cfg_t), .default_p(mode_default_lp)) u_mode_client (
      .bus_i        (mode_bus.client),
      .recv_clk_i   (recv_clk_i),
      .recv_reset_i (recv_reset_i),
      .recv_new_o   (mode_new_o),
      .recv_data_o  (mode_o)
   );

endmodule

// File: dv/tb_tag_subsystem.sv
/*
 * tag subsystem testbench
 * drives host commands in the tag domain, predicts each client's
 * payload from the command and checks every receive-side pulse
 */
`timescale 1ns/100ps

module tb_tag_subsystem;

   import tag_pkg::*;

   // commands and receive resets over all tests, sizes the watchdog
   localparam int cmd_total_lp   = 29;
   localparam int cycle_limit_lp = 2 * cmd_total_lp * (max_width_lp + 2 + 40);

   logic tag_clk, tag_reset, tag_en, recv_clk, recv_reset;
   logic cmd_valid, busy, clkdiv_new, mode_new;
   client_sel_t             cmd_sel, sel;
   logic [max_width_lp-1:0] cmd_data, data;
   clkdiv_cfg_t             clkdiv, clkdiv_cur;
   mode_cfg_t               mode, mode_cur;

   // scoreboard, pending values per client
   clkdiv_cfg_t clkdiv_q[$];
   mode_cfg_t   mode_q[$];

   integer seed;
   string  test_name;
   int errors, checks, tests, start_errors, cycle_count;
   int clkdiv_pulses, mode_pulses, start_clkdiv, start_mode, n_clkdiv, n_mode;

   tag_subsystem_top u_dut (
      .tag_clk_i    (tag_clk),
      .tag_reset_i  (tag_reset),
      .tag_en_i     (tag_en),
      .recv_clk_i   (recv_clk),
      .recv_reset_i (recv_reset),
      .cmd_valid_i  (cmd_valid),
      .cmd_sel_i    (cmd_sel),
      .cmd_data_i   (cmd_data),
      .busy_o       (busy),
      .clkdiv_new_o (clkdiv_new),
      .clkdiv_o     (clkdiv),
      .mode_new_o   (mode_new),
      .mode_o       (mode)
   );

   initial
   begin
      tag_clk = 1'b0;
      forever #2 tag_clk = ~tag_clk;
   end

   // 6 ns receive clock, offset by 1 ns from the tag clock
   initial
   begin
      recv_clk = 1'b0;
      #1;
      forever #3 recv_clk = ~recv_clk;
   end

   // expected payload is the low W bits of the command
   function automatic logic [max_width_lp-1:0] expected_payload(
      input client_sel_t sel_v, input logic [max_width_lp-1:0] data_v);
      int                      width;
      logic [max_width_lp-1:0] exp_v;
      width = (sel_v == client_mode_e) ? mode_width_lp : clkdiv_width_lp;
      exp_v = '0;
      for (int i = 0; i < width; i++)
         exp_v[i] = data_v[i];
      return exp_v;
   endfunction

   task automatic check_clkdiv(input string name, input clkdiv_cfg_t exp, input clkdiv_cfg_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[ERROR] %s: clkdiv_o expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_mode(input string name, input mode_cfg_t exp, input mode_cfg_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("[ERROR] %s: mode_o expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_pulse_count(input string name, input string sig, input int exp,
                                    input int act);
      checks++;
      if (act != exp)
      begin
         errors++;
         $display("[ERROR] %s: %s pulses expected %0d, actual %0d", name, sig, exp, act);
      end
   endtask

   // compares every pulse, sampled mid-cycle where outputs are settled
   always @(negedge recv_clk)
   begin
      if (!recv_reset && clkdiv_new)
      begin
         clkdiv_pulses++;
         if (clkdiv_q.size() == 0)
         begin
            errors++;
            $display("%s: clkdiv_new_o pulsed with no write pending", test_name);
         end
         else
         begin
            clkdiv_cur = clkdiv_q.pop_front();
            check_clkdiv(test_name, clkdiv_cur, clkdiv);
         end
      end
      if (!recv_reset && mode_new)
      begin
         mode_pulses++;
         if (mode_q.size() == 0)
         begin
            errors++;
            $display("%s: mode_new_o pulsed with no write pending", test_name);
         end
         else
         begin
            mode_cur = mode_q.pop_front();
            check_mode(test_name, mode_cur, mode);
         end
      end
   end

   task automatic wait_idle();
      @(posedge tag_clk);
      while (busy)
         @(posedge tag_clk);
   endtask

   // one-cycle strobe, taken by the master on the edge after busy is seen low
   task automatic send_cmd(input client_sel_t sel_v, input logic [max_width_lp-1:0] data_v);
      wait_idle();
      cmd_valid <= 1'b1;
      cmd_sel   <= sel_v;
      cmd_data  <= data_v;
      @(posedge tag_clk);
      cmd_valid <= 1'b0;
   endtask

   task automatic write_client(input client_sel_t sel_v, input logic [max_width_lp-1:0] data_v);
      logic [max_width_lp-1:0] exp_v;
      exp_v = expected_payload(sel_v, data_v);
      if (sel_v == client_mode_e)
         mode_q.push_back(mode_cfg_t'(exp_v));
      else
         clkdiv_q.push_back(clkdiv_cfg_t'(exp_v[clkdiv_width_lp-1:0]));
      send_cmd(sel_v, data_v);
   endtask

   // strobe right after an accepted command, master is shifting
   task automatic strobe_while_busy(input logic [max_width_lp-1:0] data_v);
      @(posedge tag_clk);
      if (!busy)
      begin
         errors++;
         $display("%s: busy_o was low right after an accepted command", test_name);
      end
      cmd_valid <= 1'b1;
      cmd_sel   <= client_mode_e;
      cmd_data  <= data_v;
      @(posedge tag_clk);
      cmd_valid <= 1'b0;
   endtask

   task automatic pulse_recv_reset();
      @(posedge recv_clk);
      recv_reset <= 1'b1;
      repeat (8) @(posedge recv_clk);
      recv_reset <= 1'b0;
   endtask

   // empty scoreboard, then a quiet window for stray pulses
   task automatic wait_delivered();
      while (clkdiv_q.size() != 0 || mode_q.size() != 0)
         @(negedge recv_clk);
      repeat (12) @(negedge recv_clk);
   endtask

   task automatic start_test(input string name);
      test_name    = name;
      start_errors = errors;
      start_clkdiv = clkdiv_pulses;
      start_mode   = mode_pulses;
   endtask

   task automatic end_test(input int clkdiv_exp, input int mode_exp);
      check_pulse_count(test_name, "clkdiv_new_o", clkdiv_exp, clkdiv_pulses - start_clkdiv);
      check_pulse_count(test_name, "mode_new_o", mode_exp, mode_pulses - start_mode);
      check_clkdiv(test_name, clkdiv_cur, clkdiv);
      check_mode(test_name, mode_cur, mode);
      tests++;
      if (errors == start_errors)
         $display("test %-18s ok", test_name);
      else
         $display("test %-18s %0d errors", test_name, errors - start_errors);
   endtask

   initial
   begin
      seed       = 32'h45c86037;
      tag_reset  <= 1'b1;
      recv_reset <= 1'b1;
      tag_en     <= 1'b1;
      cmd_valid  <= 1'b0;
      cmd_sel    <= client_clkdiv_e;
      cmd_data   <= '0;
      clkdiv_cur = clkdiv_default_lp;
      mode_cur   = mode_default_lp;

      // 1: one pulse per client with the defaults after receive reset
      start_test("reset_defaults");
      clkdiv_q.push_back(clkdiv_default_lp);
      mode_q.push_back(mode_default_lp);
      repeat (8) @(posedge tag_clk);
      tag_reset <= 1'b0;
      pulse_recv_reset();
      wait_delivered();
      end_test(1, 1);

      // 2: clkdiv write, mode side stays quiet
      start_test("clkdiv_write");
      write_client(client_clkdiv_e, 12'($random(seed)));
      wait_delivered();
      end_test(1, 0);

      // 3: upper bits set, only the low W bits arrive
      start_test("lsb_first");
      write_client(client_mode_e, 12'hF3A);
      write_client(client_clkdiv_e, 12'hE5B);
      wait_delivered();
      end_test(1, 1);

      // 4: random writes as soon as busy falls, one ignored strobe
      start_test("random_burst");
      n_clkdiv = 0;
      n_mode   = 0;
      for (int i = 0; i < 20; i++)
      begin
         sel  = ($random(seed) & 1) ? client_mode_e : client_clkdiv_e;
         data = 12'($random(seed));
         write_client(sel, data);
         if (sel == client_mode_e)
            n_mode++;
         else
            n_clkdiv++;
         if (i == 9)
            strobe_while_busy(12'($random(seed)));
      end
      wait_delivered();
      end_test(n_clkdiv, n_mode);

      // 5: writes with en low change nothing, then en high delivers again
      start_test("enable_low");
      @(posedge tag_clk);
      tag_en <= 1'b0;
      send_cmd(client_clkdiv_e, 12'($random(seed)));
      send_cmd(client_mode_e, 12'($random(seed)));
      wait_idle();
      // toggle still crosses, give it time to settle
      repeat (20) @(posedge tag_clk);
      @(negedge recv_clk);
      check_clkdiv(test_name, clkdiv_cur, clkdiv);
      check_mode(test_name, mode_cur, mode);
      @(posedge tag_clk);
      tag_en <= 1'b1;
      write_client(client_clkdiv_e, 12'($random(seed)));
      wait_delivered();
      end_test(1, 0);

      // 6: second receive reset brings back both defaults
      start_test("recv_reset_again");
      clkdiv_q.push_back(clkdiv_default_lp);
      mode_q.push_back(mode_default_lp);
      pulse_recv_reset();
      wait_delivered();
      end_test(1, 1);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // watchdog on the tag clock
   initial
   begin
      cycle_count = 0;
      while (cycle_count < cycle_limit_lp)
      begin
         @(posedge tag_clk);
         cycle_count++;
      end
      $display("timeout: tests did not finish within %0d tag clock cycles", cycle_limit_lp);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: src.f
rtl/tag_pkg.sv
rtl/tag_bus_if.sv
rtl/tag_bit_counter.sv
rtl/tag_toggle_sync.sv
rtl/tag_master_fsm.sv
rtl/tag_client.sv
rtl/tag_subsystem_top.sv
dv/tb_tag_subsystem.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the tag subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_tag_subsystem -f src.f -o sim_tag

status=0
./obj_dir/sim_tag > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF "*** FAILED ***" sim.log; then
   echo "simulation failed"
   exit 1
fi
if [ "$status" -ne 0 ] || ! grep -qF "*** PASSED ***" sim.log; then
   echo "simulation did not complete"
   exit 1
fi
echo "simulation passed"
